// ==== cluster_pkg.sv ====
package cluster_pkg;

  // default bus width for thread address and data words
  parameter int ADDR_W_DEFAULT = 32;

  // default number of cpu slots in the cluster
  parameter int N_CPUS_DEFAULT = 4;

  // words reserved in front of every thread image
  // the first usable word sits right after them
  parameter int THREAD_HEADER_SPACE = 16;

  // operation carried by a request
  // start takes the head of the idle list
  // end retires one active rank
  typedef enum logic {
    OP_START = 1'b0,
    OP_END   = 1'b1
  } req_op_t;

  // list rules, for reference
  //
  // active list
  //   ranks 0 .. active count - 1
  //   start appends at the tail
  //   end removes a rank, higher ranks move down
  //
  // idle list
  //   ranks 0 .. idle count - 1
  //   start removes rank 0, every other idle rank moves down
  //   end appends the retired slot at the tail
  //
  // after reset all slots idle, slot k at idle rank k
  //
  // pipeline
  //   cycle 1  dispatcher broadcast or reject
  //   cycle 2  slot ranks updated, target response
  //   cycle 3  completion from the collector

endpackage

// ==== cluster_top.sv ====
`timescale 1ns/1ps

module cluster_top #(
  parameter int N_CPUS = cluster_pkg::N_CPUS_DEFAULT,
  parameter int ADDR_W = cluster_pkg::ADDR_W_DEFAULT,
  // rank width, at least one bit
  localparam int RANK_W = (N_CPUS > 1) ? $clog2(N_CPUS) : 1
) (
  input  logic                 clk,
  input  logic                 ext_rst_b,
  // request strobe
  input  logic                 req_valid,
  input  cluster_pkg::req_op_t req_op,
  input  logic [RANK_W-1:0]    req_rank,
  input  logic [ADDR_W-1:0]    req_addr,
  input  logic [ADDR_W-1:0]    req_data,
  // completion, three cycles after an accepted request
  output logic                 done_valid,
  output cluster_pkg::req_op_t done_op,
  output logic [RANK_W-1:0]    done_slot,
  output logic [RANK_W-1:0]    done_rank,
  output logic [ADDR_W-1:0]    done_base_addr,
  output logic [ADDR_W-1:0]    done_base_addr_data,
  // one cycle after a refused request
  output logic                 reject
);
  import cluster_pkg::*;

  // dispatcher to slots
  logic                          bcast_valid;
  req_op_t                       bcast_op;
  logic [RANK_W:0]               bcast_rank;
  logic [RANK_W:0]               bcast_count;
  logic [ADDR_W-1:0]             bcast_addr;
  logic [ADDR_W-1:0]             bcast_data;

  // slots to collector, one lane each
  logic [N_CPUS-1:0]             resp_valid;
  req_op_t [N_CPUS-1:0]          resp_op;
  logic [N_CPUS-1:0][RANK_W-1:0] resp_rank;
  logic [N_CPUS-1:0][ADDR_W-1:0] resp_base_addr;
  logic [N_CPUS-1:0][ADDR_W-1:0] resp_base_addr_data;

  token_dispatcher #(
    .N_CPUS (N_CPUS),
    .ADDR_W (ADDR_W),
    .RANK_W (RANK_W)
  ) u_dispatcher (
    .clk         (clk),
    .ext_rst_b   (ext_rst_b),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_rank    (req_rank),
    .req_addr    (req_addr),
    .req_data    (req_data),
    .bcast_valid (bcast_valid),
    .bcast_op    (bcast_op),
    .bcast_rank  (bcast_rank),
    .bcast_count (bcast_count),
    .bcast_addr  (bcast_addr),
    .bcast_data  (bcast_data),
    .reject      (reject)
  );

  // one slot per cpu, id fixes the initial idle rank
  for (genvar k = 0; k < N_CPUS; k++) begin : g_slot
    thread_slot #(
      .N_CPUS  (N_CPUS),
      .ADDR_W  (ADDR_W),
      .RANK_W  (RANK_W),
      .SLOT_ID (k)
    ) u_slot (
      .clk                 (clk),
      .ext_rst_b           (ext_rst_b),
      .bcast_valid         (bcast_valid),
      .bcast_op            (bcast_op),
      .bcast_rank          (bcast_rank),
      .bcast_count         (bcast_count),
      .bcast_addr          (bcast_addr),
      .bcast_data          (bcast_data),
      .resp_valid          (resp_valid[k]),
      .resp_op             (resp_op[k]),
      .resp_rank           (resp_rank[k]),
      .resp_base_addr      (resp_base_addr[k]),
      .resp_base_addr_data (resp_base_addr_data[k])
    );
  end

  done_collector #(
    .N_CPUS (N_CPUS),
    .ADDR_W (ADDR_W),
    .RANK_W (RANK_W)
  ) u_collector (
    .clk                 (clk),
    .ext_rst_b           (ext_rst_b),
    .resp_valid          (resp_valid),
    .resp_op             (resp_op),
    .resp_rank           (resp_rank),
    .resp_base_addr      (resp_base_addr),
    .resp_base_addr_data (resp_base_addr_data),
    .done_valid          (done_valid),
    .done_op             (done_op),
    .done_slot           (done_slot),
    .done_rank           (done_rank),
    .done_base_addr      (done_base_addr),
    .done_base_addr_data (done_base_addr_data)
  );

endmodule

// ==== compile.f ====
cluster_pkg.sv
token_dispatcher.sv
thread_slot.sv
done_collector.sv
cluster_top.sv
tb_cluster.sv

// ==== done_collector.sv ====
`timescale 1ns/1ps

module done_collector #(
  parameter int N_CPUS = cluster_pkg::N_CPUS_DEFAULT,
  parameter int ADDR_W = cluster_pkg::ADDR_W_DEFAULT,
  parameter int RANK_W = (N_CPUS > 1) ? $clog2(N_CPUS) : 1
) (
  input  logic                                clk,
  input  logic                                ext_rst_b,
  // one lane per slot
  input  logic [N_CPUS-1:0]                   resp_valid,
  input  cluster_pkg::req_op_t [N_CPUS-1:0]   resp_op,
  input  logic [N_CPUS-1:0][RANK_W-1:0]       resp_rank,
  input  logic [N_CPUS-1:0][ADDR_W-1:0]       resp_base_addr,
  input  logic [N_CPUS-1:0][ADDR_W-1:0]       resp_base_addr_data,
  // merged completion
  output logic                                done_valid,
  output cluster_pkg::req_op_t                done_op,
  output logic [RANK_W-1:0]                   done_slot,
  output logic [RANK_W-1:0]                   done_rank,
  output logic [ADDR_W-1:0]                   done_base_addr,
  output logic [ADDR_W-1:0]                   done_base_addr_data
);
  import cluster_pkg::*;

  logic              any_resp;
  logic [RANK_W-1:0] sel_slot;
  req_op_t           sel_op;
  logic [RANK_W-1:0] sel_rank;
  logic [ADDR_W-1:0] sel_base;
  logic [ADDR_W-1:0] sel_base_data;

  // one-hot to index, plus lane select
  always_comb begin
    any_resp      = |resp_valid;
    sel_slot      = '0;
    sel_op        = OP_START;
    sel_rank      = '0;
    sel_base      = '0;
    sel_base_data = '0;
    for (int i = 0; i < N_CPUS; i++) begin
      // at most one lane raised per cycle
      if (resp_valid[i]) begin
        sel_slot      = RANK_W'(i);
        sel_op        = resp_op[i];
        sel_rank      = resp_rank[i];
        sel_base      = resp_base_addr[i];
        sel_base_data = resp_base_addr_data[i];
      end
    end
  end

  // completion strobe
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      done_valid <= 1'b0;
    end else begin
      done_valid <= any_resp;
    end
  end

  // completion payload, held between strobes
  always_ff @(posedge clk) begin
    if (any_resp) begin
      done_op             <= sel_op;
      done_slot           <= sel_slot;
      done_rank           <= sel_rank;
      done_base_addr      <= sel_base;
      done_base_addr_data <= sel_base_data;
    end
  end

  // list rules across all slots give a single target per op
  a_resp_onehot: assert property (
    @(posedge clk) disable iff (ext_rst_b)
    $onehot0(resp_valid)
  ) else $error("several slots answered: %b", resp_valid);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the cluster testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cluster \
  -f compile.f -o tb_cluster_sim > build.log 2>&1 \
  && ./obj_dir/tb_cluster_sim > sim.log 2>&1 \
  || { echo "build or run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

// ==== tb_cluster.sv ====
`timescale 1ns/1ps

module tb_cluster;
  import cluster_pkg::*;

  localparam int N  = N_CPUS_DEFAULT;
  localparam int AW = ADDR_W_DEFAULT;
  localparam int RW = (N > 1) ? $clog2(N) : 1;
  localparam logic [AW-1:0] HDR = AW'(THREAD_HEADER_SPACE);

  logic          clk;
  logic          ext_rst_b;
  logic          req_valid;
  req_op_t       req_op;
  logic [RW-1:0] req_rank;
  logic [AW-1:0] req_addr;
  logic [AW-1:0] req_data;
  logic          done_valid;
  req_op_t       done_op;
  logic [RW-1:0] done_slot;
  logic [RW-1:0] done_rank;
  logic [AW-1:0] done_base_addr;
  logic [AW-1:0] done_base_addr_data;
  logic          reject;

  // reference lists, index is the rank
  int            active_q[$];
  int            idle_q[$];
  // bases last handed to each slot
  logic [AW-1:0] base_a [N];
  logic [AW-1:0] base_d [N];

  // expectation of the request being driven now
  logic          new_v;
  logic          new_rej;
  req_op_t       new_op;
  logic [RW-1:0] new_slot;
  logic [RW-1:0] new_rank;
  logic [AW-1:0] new_ba;
  logic [AW-1:0] new_bd;

  // three-deep expectation pipe
  // last stage lines up with done_*
  logic [2:0]    pipe_v;
  req_op_t       pipe_op [3];
  logic [RW-1:0] pipe_slot [3];
  logic [RW-1:0] pipe_rank [3];
  logic [AW-1:0] pipe_ba [3];
  logic [AW-1:0] pipe_bd [3];
  logic          rej_exp;

  logic [15:0]   lfsr;
  int            errors;
  int            checks;
  int            tests;
  bit            timed_out;

  cluster_top #(
    .N_CPUS (N),
    .ADDR_W (AW)
  ) DUT (
    .clk                 (clk),
    .ext_rst_b           (ext_rst_b),
    .req_valid           (req_valid),
    .req_op              (req_op),
    .req_rank            (req_rank),
    .req_addr            (req_addr),
    .req_data            (req_data),
    .done_valid          (done_valid),
    .done_op             (done_op),
    .done_slot           (done_slot),
    .done_rank           (done_rank),
    .done_base_addr      (done_base_addr),
    .done_base_addr_data (done_base_addr_data),
    .reject              (reject)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // accepted requests ride the pipe, rejects get one stage
  always @(posedge clk) begin
    if (ext_rst_b) begin
      pipe_v  <= '0;
      rej_exp <= 1'b0;
    end else begin
      pipe_v       <= {pipe_v[1:0], new_v && req_valid};
      pipe_op[0]   <= new_op;
      pipe_slot[0] <= new_slot;
      pipe_rank[0] <= new_rank;
      pipe_ba[0]   <= new_ba;
      pipe_bd[0]   <= new_bd;
      for (int i = 2; i > 0; i--) begin
        pipe_op[i]   <= pipe_op[i-1];
        pipe_slot[i] <= pipe_slot[i-1];
        pipe_rank[i] <= pipe_rank[i-1];
        pipe_ba[i]   <= pipe_ba[i-1];
        pipe_bd[i]   <= pipe_bd[i-1];
      end
      // reject shows one cycle after the request
      rej_exp <= new_rej && req_valid;
      if (pipe_v[2] || rej_exp) begin
        checks <= checks + 1;
      end
    end
  end

  a_valid: assert property (@(posedge clk) disable iff (ext_rst_b)
    done_valid == pipe_v[2])
    else begin
      errors++;
      $display("[FAIL] done_valid got %h expected %h",
               $sampled(done_valid), $sampled(pipe_v[2]));
    end
  a_op: assert property (@(posedge clk) disable iff (ext_rst_b)
    pipe_v[2] |-> done_op == pipe_op[2])
    else begin
      errors++;
      $display("[FAIL] done_op got %h expected %h",
               $sampled(done_op), $sampled(pipe_op[2]));
    end
  a_slot: assert property (@(posedge clk) disable iff (ext_rst_b)
    pipe_v[2] |-> done_slot == pipe_slot[2])
    else begin
      errors++;
      $display("[FAIL] done_slot got %h expected %h",
               $sampled(done_slot), $sampled(pipe_slot[2]));
    end
  a_rank: assert property (@(posedge clk) disable iff (ext_rst_b)
    pipe_v[2] |-> done_rank == pipe_rank[2])
    else begin
      errors++;
      $display("[FAIL] done_rank got %h expected %h",
               $sampled(done_rank), $sampled(pipe_rank[2]));
    end
  a_base: assert property (@(posedge clk) disable iff (ext_rst_b)
    pipe_v[2] |-> done_base_addr == pipe_ba[2])
    else begin
      errors++;
      $display("[FAIL] done_base_addr got %h expected %h",
               $sampled(done_base_addr), $sampled(pipe_ba[2]));
    end
  a_base_data: assert property (@(posedge clk) disable iff (ext_rst_b)
    pipe_v[2] |-> done_base_addr_data == pipe_bd[2])
    else begin
      errors++;
      $display("[FAIL] done_base_addr_data got %h expected %h",
               $sampled(done_base_addr_data), $sampled(pipe_bd[2]));
    end
  a_reject: assert property (@(posedge clk) disable iff (ext_rst_b) reject == rej_exp)
    else begin
      errors++;
      $display("[FAIL] reject got %h expected %h", $sampled(reject), $sampled(rej_exp));
    end

  // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // drive one request for one cycle and update the reference lists
  task automatic issue_request(input req_op_t op, input logic [RW-1:0] rank,
                               input logic [AW-1:0] addr, input logic [AW-1:0] data);
    int slot;
    slot      = 0;
    req_valid = 1'b1;
    req_op    = op;
    req_rank  = rank;
    req_addr  = addr;
    req_data  = data;
    new_v     = 1'b0;
    new_rej   = 1'b0;
    if (op == OP_START) begin
      if (active_q.size() == N) begin
        new_rej = 1'b1;
      end else begin
        // head of the idle list goes to the active tail
        slot = idle_q.pop_front();
        active_q.push_back(slot);
        base_a[slot] = addr + HDR;
        base_d[slot] = (data != '0) ? data + HDR : base_a[slot];
        new_rank = RW'(active_q.size() - 1);
        new_v    = 1'b1;
      end
    end else begin
      if (int'(rank) >= active_q.size()) begin
        new_rej = 1'b1;
      end else begin
        // higher ranks close the gap, slot joins the idle tail
        slot = active_q[rank];
        active_q.delete(rank);
        idle_q.push_back(slot);
        new_rank = rank;
        new_v    = 1'b1;
      end
    end
    new_op   = op;
    new_slot = RW'(slot);
    new_ba   = base_a[slot];
    new_bd   = base_d[slot];
    @(negedge clk);
    req_valid = 1'b0;
    new_v     = 1'b0;
    new_rej   = 1'b0;
  endtask

  task automatic wait_for_done(input int limit);
    int n;
    n = 0;
    while (!done_valid && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!done_valid) begin
      timed_out = 1'b1;
      $display("no completion seen within %0d cycles", limit);
    end
  endtask

  // until nothing is left in flight
  task automatic drain_pipe(input int limit);
    int n;
    n = 0;
    while ((pipe_v != '0 || rej_exp) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (pipe_v != '0 || rej_exp) begin
      timed_out = 1'b1;
      $display("requests still in flight after %0d cycles", limit);
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s finished, errors so far %0d", tests, name, errors);
  endtask

  task automatic run_tests();
    // quiet after reset, then slot 0 takes rank 0
    repeat (5) @(negedge clk);
    issue_request(OP_START, '0, 32'h0000_1000, 32'h0000_2000);
    wait_for_done(8);
    if (timed_out) return;
    drain_pipe(8);
    if (timed_out) return;
    report_test("reset and first start");
    // data base with and without data
    issue_request(OP_START, '0, 32'h0000_3000, 32'h0000_5000);
    issue_request(OP_START, '0, 32'h0000_7000, '0);
    drain_pipe(8);
    if (timed_out) return;
    report_test("base addresses");
    // last idle slot, then one start too many
    issue_request(OP_START, '0, 32'h0000_9000, 32'h0000_a000);
    issue_request(OP_START, '0, 32'h0000_b000, 32'h0000_c000);
    drain_pipe(8);
    if (timed_out) return;
    report_test("fill and overflow");
    // middle rank out, then rank 0, then refill from the idle head
    issue_request(OP_END, 2'd1, '0, '0);
    issue_request(OP_END, 2'd0, '0, '0);
    issue_request(OP_START, '0, 32'h0001_0000, 32'h0001_1000);
    issue_request(OP_START, '0, 32'h0001_2000, '0);
    drain_pipe(8);
    if (timed_out) return;
    report_test("end and rank shift");
    // rank 3 twice, the second is past the count
    issue_request(OP_END, 2'd3, '0, '0);
    issue_request(OP_END, 2'd3, '0, '0);
    issue_request(OP_END, 2'd2, '0, '0);
    drain_pipe(8);
    if (timed_out) return;
    report_test("end out of range");
    for (int i = 0; i < 40; i++) begin
      issue_request(take_bits(1) ? OP_END : OP_START, RW'(take_bits(RW)),
                    AW'(take_bits(AW)), take_bits(1) ? AW'(take_bits(AW)) : '0);
    end
    drain_pipe(10);
    if (timed_out) return;
    report_test("random back to back");
  endtask

  initial begin
    ext_rst_b = 1'b1;
    req_valid = 1'b0;
    req_op    = OP_START;
    req_rank  = '0;
    req_addr  = '0;
    req_data  = '0;
    new_v     = 1'b0;
    new_rej   = 1'b0;
    new_op    = OP_START;
    new_slot  = '0;
    new_rank  = '0;
    new_ba    = '0;
    new_bd    = '0;
    lfsr      = 16'd17258;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    timed_out = 1'b0;
    // slot k idle at rank k
    for (int k = 0; k < N; k++) begin
      idle_q.push_back(k);
      base_a[k] = '0;
      base_d[k] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    ext_rst_b = 1'b0;
    run_tests();
    if (timed_out) begin
      $display("run stopped early on a timeout");
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (!timed_out && errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== thread_slot.sv ====
`timescale 1ns/1ps

module thread_slot #(
  parameter int N_CPUS  = cluster_pkg::N_CPUS_DEFAULT,
  parameter int ADDR_W  = cluster_pkg::ADDR_W_DEFAULT,
  parameter int RANK_W  = (N_CPUS > 1) ? $clog2(N_CPUS) : 1,
  parameter int SLOT_ID = 0
) (
  input  logic                 clk,
  input  logic                 ext_rst_b,
  // broadcast from the dispatcher
  input  logic                 bcast_valid,
  input  cluster_pkg::req_op_t bcast_op,
  input  logic [RANK_W:0]      bcast_rank,
  input  logic [RANK_W:0]      bcast_count,
  input  logic [ADDR_W-1:0]    bcast_addr,
  input  logic [ADDR_W-1:0]    bcast_data,
  // response lane of this slot
  output logic                 resp_valid,
  output cluster_pkg::req_op_t resp_op,
  output logic [RANK_W-1:0]    resp_rank,
  output logic [ADDR_W-1:0]    resp_base_addr,
  output logic [ADDR_W-1:0]    resp_base_addr_data
);
  import cluster_pkg::*;

  localparam logic [ADDR_W-1:0] HDR_OFS = ADDR_W'(THREAD_HEADER_SPACE);
  localparam logic [RANK_W:0]   N_SLOTS = (RANK_W + 1)'(N_CPUS);

  // list membership, 1 on the active list
  logic              active;
  // place in whichever list the slot is on
  logic [RANK_W-1:0] rank;

  logic              hit_start;
  logic              hit_end;
  logic              shift_start;
  logic              shift_end;
  logic [RANK_W:0]   idle_tail;
  logic [ADDR_W-1:0] base_addr_nxt;
  logic [ADDR_W-1:0] base_data_nxt;

  always_comb begin
    // head of the idle list takes a start
    hit_start   = bcast_valid && (bcast_op == OP_START) && !active && (rank == '0);
    // rest of the idle list moves up
    shift_start = bcast_valid && (bcast_op == OP_START) && !active && (rank != '0);
    // the active slot holding the ended rank
    hit_end     = bcast_valid && (bcast_op == OP_END) && active &&
                  ({1'b0, rank} == bcast_rank);
    // active ranks above the hole close it
    shift_end   = bcast_valid && (bcast_op == OP_END) && active &&
                  ({1'b0, rank} > bcast_rank);
    // idle count before the end, i.e. the new idle tail
    idle_tail   = N_SLOTS - bcast_count;
    // first usable word past the thread header
    base_addr_nxt = bcast_addr + HDR_OFS;
    // data area falls back to the code area when no data given
    base_data_nxt = (bcast_data != '0) ? bcast_data + HDR_OFS : base_addr_nxt;
  end

  // list state
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      active     <= 1'b0;
      // slot k starts at idle rank k
      rank       <= RANK_W'(SLOT_ID);
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= hit_start || hit_end;
      if (hit_start) begin
        active <= 1'b1;
        rank   <= bcast_rank[RANK_W-1:0];
      end else if (hit_end) begin
        active <= 1'b0;
        rank   <= idle_tail[RANK_W-1:0];
      end else if (shift_start || shift_end) begin
        rank <= rank - 1'b1;
      end
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (hit_start || hit_end) begin
      resp_op   <= bcast_op;
      // new active rank on start, retired rank on end
      resp_rank <= bcast_rank[RANK_W-1:0];
    end
    // bases stay with the thread until the next start here
    if (hit_start) begin
      resp_base_addr      <= base_addr_nxt;
      resp_base_addr_data <= base_data_nxt;
    end
  end

  // rank bounded by the length of the list the slot is on
  // active count from the broadcast, idle count is the rest
  // relies on the dispatcher rejecting out-of-range ops
  a_rank_bound: assert property (
    @(posedge clk) disable iff (ext_rst_b)
    bcast_valid |-> (active ? ({1'b0, rank} < bcast_count)
                            : ({1'b0, rank} < idle_tail))
  ) else $error("slot %0d rank %0d out of range", SLOT_ID, rank);

endmodule

// ==== token_dispatcher.sv ====
`timescale 1ns/1ps

module token_dispatcher #(
  parameter int N_CPUS = cluster_pkg::N_CPUS_DEFAULT,
  parameter int ADDR_W = cluster_pkg::ADDR_W_DEFAULT,
  parameter int RANK_W = (N_CPUS > 1) ? $clog2(N_CPUS) : 1
) (
  input  logic                 clk,
  input  logic                 ext_rst_b,
  // request strobe, one cycle wide
  input  logic                 req_valid,
  input  cluster_pkg::req_op_t req_op,
  input  logic [RANK_W-1:0]    req_rank,
  input  logic [ADDR_W-1:0]    req_addr,
  input  logic [ADDR_W-1:0]    req_data,
  // broadcast to every slot
  output logic                 bcast_valid,
  output cluster_pkg::req_op_t bcast_op,
  output logic [RANK_W:0]      bcast_rank,
  output logic [RANK_W:0]      bcast_count,
  output logic [ADDR_W-1:0]    bcast_addr,
  output logic [ADDR_W-1:0]    bcast_data,
  output logic                 reject
);
  import cluster_pkg::*;

  // count needs one bit more than a rank, it reaches N_CPUS
  localparam int CNT_W = RANK_W + 1;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(N_CPUS);

  // number of slots on the active list
  logic [CNT_W-1:0] active_cnt;
  logic             start_ok;
  logic             end_ok;
  logic             accept;

  // request checks against the current count
  always_comb begin
    // start only while an idle slot is left
    start_ok = (req_op == OP_START) && (active_cnt != FULL_CNT);
    // end only for a rank that is on the active list
    end_ok   = (req_op == OP_END) && ({1'b0, req_rank} < active_cnt);
    accept   = start_ok || end_ok;
  end

  // strobes and active count
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      bcast_valid <= 1'b0;
      reject      <= 1'b0;
      active_cnt  <= '0;
    end else begin
      bcast_valid <= req_valid && accept;
      reject      <= req_valid && !accept;
      // count moves with the broadcast
      // so the next request already sees it
      if (req_valid && start_ok) begin
        active_cnt <= active_cnt + 1'b1;
      end else if (req_valid && end_ok) begin
        active_cnt <= active_cnt - 1'b1;
      end
    end
  end

  // broadcast payload
  always_ff @(posedge clk) begin
    if (req_valid && accept) begin
      bcast_op    <= req_op;
      // start lands at the tail, rank equal to the old count
      bcast_rank  <= start_ok ? active_cnt : {1'b0, req_rank};
      // slots derive the idle tail from this
      bcast_count <= active_cnt;
      bcast_addr  <= req_addr;
      bcast_data  <= req_data;
    end
  end

  // active list can never hold more than the slot count
  a_cnt_bound: assert property (
    @(posedge clk) disable iff (ext_rst_b)
    active_cnt <= FULL_CNT
  ) else $error("active count %0d above %0d", active_cnt, N_CPUS);

endmodule
